//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_switch_top
RTL_TOP    := switch_top
FILELIST   := verilog.f
OBJ_DIR    := obj_dir
VFLAGS     := --timing --assert
LINT_FLAGS := --lint-only $(VFLAGS)
SIM_FLAGS  := --binary -j 0 $(VFLAGS) --Mdir $(OBJ_DIR)
PASS_MSG   := Simulation finished: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

# status comes from the search for the pass line
sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- include/switch_cfg.svh
`ifndef SWITCH_CFG_SVH
`define SWITCH_CFG_SVH

// number of switch ports
`define SW_NUM_PORTS 4

// address table entries
`define SW_TABLE_DEPTH 16

// table index width, one nibble of the mac
`define SW_HASH_W 4

// frame length field
`define SW_LEN_W 16

// ethernet mac address
`define SW_MAC_W 48

`endif

//--- verification/tb_switch_top.sv
`timescale 1ns/100ps
`default_nettype none
`include "switch_cfg.svh"

module tb_switch_top import switch_pkg::*, mac_table_pkg::*; ();

    localparam int NP              = `SW_NUM_PORTS;
    localparam int FRAMES_PER_PORT = 100;
    localparam int NUM_FRAMES      = NP * FRAMES_PER_PORT;
    // about 40 cycles a frame at worst plus reset and drain
    localparam int MAX_CYCLES      = NUM_FRAMES * 40 + 4000;
    localparam int POOL_SIZE       = 8;

    logic                          clk;
    logic                          rst_n;
    port_map_t                     link;
    port_map_t                     rx_valid;
    port_map_t                     rx_ready;
    logic [NP-1:0][`SW_MAC_W-1:0]  rx_dmac;
    logic [NP-1:0][`SW_MAC_W-1:0]  rx_smac;
    logic [NP-1:0][`SW_LEN_W-1:0]  rx_len;
    logic                          fwd_valid;
    logic                          fwd_ready;
    port_map_t                     fwd_portmap;
    fwd_kind_t                     fwd_kind;
    port_id_t                      fwd_src;
    logic [`SW_MAC_W-1:0]          fwd_dmac;
    logic [`SW_MAC_W-1:0]          fwd_smac;
    logic [`SW_LEN_W-1:0]          fwd_len;

    // reference address table
    logic                 ref_vld  [`SW_TABLE_DEPTH];
    logic [`SW_MAC_W-1:0] ref_mac  [`SW_TABLE_DEPTH];
    port_id_t             ref_port [`SW_TABLE_DEPTH];

    logic [`SW_MAC_W-1:0] mac_pool [POOL_SIZE];
    frame_hdr_t           sent_q [NP][$];
    int                   offered [NP];
    int                   wait_cnt [NP];
    int                   kind_cnt [3];
    int                   errors;
    int                   in_cnt;
    int                   out_cnt;
    int                   cycles = 0;
    int unsigned          seed;
    port_map_t            rx_take;
    logic                 fwd_take;

    switch_top uut (
        .clk           (clk),
        .i_rst_n       (rst_n),
        .i_link        (link),
        .i_rx_valid    (rx_valid),
        .o_rx_ready    (rx_ready),
        .i_rx_dmac     (rx_dmac),
        .i_rx_smac     (rx_smac),
        .i_rx_len      (rx_len),
        .o_fwd_valid   (fwd_valid),
        .i_fwd_ready   (fwd_ready),
        .o_fwd_portmap (fwd_portmap),
        .o_fwd_kind    (fwd_kind),
        .o_fwd_src     (fwd_src),
        .o_fwd_dmac    (fwd_dmac),
        .o_fwd_smac    (fwd_smac),
        .o_fwd_len     (fwd_len)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run stopped after %0d cycles, %0d of %0d frames forwarded",
                     cycles, out_cnt, NUM_FRAMES);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    a_fwd_hold : assert property (@(posedge clk) disable iff (!rst_n)
        fwd_valid && !fwd_ready |=> fwd_valid && $stable(fwd_portmap) && $stable(fwd_kind) &&
            $stable(fwd_src) && $stable({fwd_dmac, fwd_smac, fwd_len}))
        else begin
            errors++;
            $display("** Error at %0t ns: forward outputs changed while stalled", $time);
        end

    a_rx_grant : assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(rx_ready) && ((rx_ready & ~rx_valid) == '0))
        else begin
            errors++;
            $display("** Error at %0t ns: receive ready %b with valid %b",
                     $time, rx_ready, rx_valid);
        end

    // a grant while stalled fills the register and the next cycle grants nothing
    a_rx_stall : assert property (@(posedge clk) disable iff (!rst_n)
        fwd_valid && !fwd_ready && (rx_ready != '0) |=> rx_ready == '0)
        else begin
            errors++;
            $display("** Error at %0t ns: port granted into a full register", $time);
        end

    // bit b of the index folds every address bit with the same position in its nibble
    function automatic tbl_idx_t table_index(input logic [`SW_MAC_W-1:0] mac);
        tbl_idx_t idx;
        idx = '0;
        for (int b = 0; b < `SW_MAC_W; b++) begin
            idx[b % 4] = idx[b % 4] ^ mac[b];
        end
        return idx;
    endfunction

    function automatic logic group_address(input logic [`SW_MAC_W-1:0] mac);
        logic [7:0] first_octet;
        first_octet = mac[`SW_MAC_W-1 -: 8];
        return first_octet[0];
    endfunction

    task automatic build_pool();
        for (int i = 0; i < POOL_SIZE; i++) begin
            mac_pool[i] = {16'($urandom), 32'($urandom)};
            mac_pool[i][40] = 1'b0;
        end
        // two flipped nibble bits cancel in the index
        mac_pool[5] = mac_pool[4] ^ 48'h0000_0011_0000;
        // group address on the same index as entry 0
        mac_pool[7] = mac_pool[0] ^ 48'h1100_0000_0000;
    endtask

    task automatic check_quiet();
        assert (fwd_valid === 1'b0 && rx_ready === '0) else begin
            errors++;
            $display("** Error at %0t ns: fwd_valid %b rx_ready %b, expected all low",
                     $time, fwd_valid, rx_ready);
        end
    endtask

    task automatic count_waits();
        for (int p = 0; p < NP; p++) begin
            if (rx_take[p]) begin
                wait_cnt[p] = 0;
            end else if (rx_valid[p] && rx_take != '0) begin
                wait_cnt[p]++;
            end
            assert (wait_cnt[p] <= 3) else begin
                errors++;
                $display("** Error at %0t ns: port %0d passed over %0d times while valid",
                         $time, p, wait_cnt[p]);
            end
        end
    endtask

    // learn first and then look up as the switch did
    task automatic check_output();
        frame_hdr_t exp_hdr;
        frame_hdr_t got_hdr;
        port_map_t  exp_map;
        port_map_t  src_bit;
        fwd_kind_t  exp_kind;
        tbl_idx_t   s_idx;
        tbl_idx_t   d_idx;
        got_hdr.dmac = fwd_dmac;
        got_hdr.smac = fwd_smac;
        got_hdr.len  = fwd_len;
        assert (sent_q[fwd_src].size() > 0) else begin
            errors++;
            $display("port %0d forwarded a header that was never accepted", fwd_src);
        end
        if (sent_q[fwd_src].size() == 0) begin
            return;
        end
        exp_hdr = sent_q[fwd_src].pop_front();
        assert (got_hdr == exp_hdr) else begin
            errors++;
            $display("** Error at %0t ns: port %0d header %h, expected %h",
                     $time, fwd_src, got_hdr, exp_hdr);
        end
        s_idx = table_index(exp_hdr.smac);
        if (!group_address(exp_hdr.smac)) begin
            ref_vld[s_idx]  = 1'b1;
            ref_mac[s_idx]  = exp_hdr.smac;
            ref_port[s_idx] = fwd_src;
        end
        d_idx   = table_index(exp_hdr.dmac);
        src_bit = port_map_t'(1) << fwd_src;
        if (group_address(exp_hdr.dmac) || !ref_vld[d_idx] ||
            ref_mac[d_idx] != exp_hdr.dmac) begin
            exp_kind = FWD_FLOOD;
            exp_map  = link & ~src_bit;
        end else if (ref_port[d_idx] == fwd_src) begin
            exp_kind = FWD_FILTER;
            exp_map  = '0;
        end else begin
            exp_kind = FWD_UNICAST;
            exp_map  = (port_map_t'(1) << ref_port[d_idx]) & link;
        end
        // empty table, only a frame sent to itself can hit
        if (out_cnt == 0 && exp_hdr.dmac != exp_hdr.smac) begin
            assert (fwd_kind == FWD_FLOOD) else begin
                errors++;
                $display("** Error at %0t ns: first frame gave %s, expected a flood",
                         $time, fwd_kind.name());
            end
        end
        assert (fwd_kind == exp_kind && fwd_portmap == exp_map) else begin
            errors++;
            $display("** Error at %0t ns: port %0d gave %s %b, expected %s %b", $time, fwd_src,
                     fwd_kind.name(), fwd_portmap, exp_kind.name(), exp_map);
        end
        kind_cnt[int'(exp_kind)]++;
        out_cnt++;
    endtask

    task automatic drive_cycle();
        frame_hdr_t hdr;
        // transfers sampled last cycle happened on the rising edge
        for (int p = 0; p < NP; p++) begin
            if (rx_take[p]) begin
                hdr.dmac = rx_dmac[p];
                hdr.smac = rx_smac[p];
                hdr.len  = rx_len[p];
                sent_q[p].push_back(hdr);
                rx_valid[p] = 1'b0;
                in_cnt++;
            end
        end
        // lookup is idle right after a result leaves
        if (fwd_take && ($urandom % 16) == 0) begin
            link = port_map_t'($urandom);
        end
        for (int p = 0; p < NP; p++) begin
            if (!rx_valid[p] && offered[p] < FRAMES_PER_PORT && ($urandom % 8) != 0) begin
                rx_dmac[p]  = mac_pool[$urandom % POOL_SIZE];
                rx_smac[p]  = mac_pool[$urandom % POOL_SIZE];
                rx_len[p]   = {2'(p), 14'(offered[p])};
                rx_valid[p] = 1'b1;
                offered[p]++;
            end
        end
        fwd_ready = ($urandom % 4) != 0;
        #1;
        rx_take  = rx_valid & rx_ready;
        fwd_take = fwd_valid && fwd_ready;
        count_waits();
        if (fwd_take) begin
            check_output();
        end
    endtask

    initial begin
        seed      = $urandom(20934);
        rst_n     = 1'b0;
        link      = '1;
        rx_valid  = '0;
        rx_dmac   = '0;
        rx_smac   = '0;
        rx_len    = '0;
        fwd_ready = 1'b0;
        errors    = 0;
        in_cnt    = 0;
        out_cnt   = 0;
        rx_take   = '0;
        fwd_take  = 1'b0;
        for (int p = 0; p < NP; p++) begin
            offered[p]  = 0;
            wait_cnt[p] = 0;
        end
        for (int k = 0; k < 3; k++) begin
            kind_cnt[k] = 0;
        end
        for (int i = 0; i < `SW_TABLE_DEPTH; i++) begin
            ref_vld[i] = 1'b0;
        end
        build_pool();

        repeat (5) begin
            @(negedge clk);
            check_quiet();
        end
        rst_n = 1'b1;
        @(negedge clk);
        check_quiet();

        while (out_cnt < NUM_FRAMES) begin
            @(negedge clk);
            drive_cycle();
        end

        // nothing more may come out once every header is accounted for
        repeat (10) begin
            @(negedge clk);
            fwd_ready = 1'b1;
            #1;
            check_quiet();
        end
        for (int p = 0; p < NP; p++) begin
            assert (sent_q[p].size() == 0) else begin
                errors++;
                $display("port %0d has %0d headers that never came out", p, sent_q[p].size());
            end
        end
        assert (in_cnt == NUM_FRAMES) else begin
            errors++;
            $display("only %0d of %0d headers were accepted", in_cnt, NUM_FRAMES);
        end
        for (int k = 0; k < 3; k++) begin
            assert (kind_cnt[k] > 0) else begin
                errors++;
                $display("decision kind %0d never occurred", k);
            end
        end

        $display("frames in %0d, out %0d, unicast %0d, flood %0d, filter %0d, errors %0d",
                 in_cnt, out_cnt, kind_cnt[0], kind_cnt[1], kind_cnt[2], errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+include
verilog/switch_pkg.sv
verilog/mac_table_pkg.sv
verilog/hdr_if.sv
verilog/interface_mux.sv
verilog/mac_lookup.sv
verilog/switch_top.sv
verification/tb_switch_top.sv

//--- verilog/hdr_if.sv
`timescale 1ns/100ps
`default_nettype none

interface hdr_if import switch_pkg::*; ();

    logic       valid;
    logic       ready;
    frame_hdr_t hdr;
    port_id_t   src;

    // mux side
    modport src_mp (
        output valid, hdr, src,
        input  ready
    );

    // lookup side
    modport dst_mp (
        input  valid, hdr, src,
        output ready
    );

endinterface

`default_nettype wire

//--- verilog/interface_mux.sv
`timescale 1ns/100ps
`default_nettype none
`include "switch_cfg.svh"

module interface_mux import switch_pkg::*; (
    input  wire                                  clk,
    input  wire                                  i_rst_n,
    input  wire port_map_t                       i_rx_valid,
    input  wire frame_hdr_t [`SW_NUM_PORTS-1:0]  i_rx_hdr,
    output port_map_t                            o_rx_ready,
    hdr_if.src_mp                                m_hdr
);

    localparam int NP = `SW_NUM_PORTS;

    logic       hold_vld;
    frame_hdr_t hold_hdr;
    port_id_t   hold_src;
    port_id_t   last_q;
    port_id_t   winner;
    logic       found;
    logic       can_load;
    port_map_t  grant;

    // search starts one past the last granted port
    always_comb begin
        port_id_t cand;
        found  = 1'b0;
        winner = last_q;
        cand   = last_q;
        for (int i = 1; i <= NP; i++) begin
            cand = port_id_t'((int'(last_q) + i) % NP);
            if (!found && i_rx_valid[cand]) begin
                found  = 1'b1;
                winner = cand;
            end
        end
    end

    // register free or draining this cycle
    assign can_load   = !hold_vld || m_hdr.ready;
    assign grant      = (found && can_load) ? (port_map_t'(1'b1) << winner) : '0;
    assign o_rx_ready = grant;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            hold_vld <= 1'b0;
            last_q   <= port_id_t'(NP - 1);
        end else if (|grant) begin
            hold_vld <= 1'b1;
            last_q   <= winner;
        end else if (m_hdr.ready) begin
            hold_vld <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (|grant) begin
            hold_hdr <= i_rx_hdr[winner];
            hold_src <= winner;
        end
    end

    assign m_hdr.valid = hold_vld;
    assign m_hdr.hdr   = hold_hdr;
    assign m_hdr.src   = hold_src;

    // the port served last yields to any other requester
    a_grant_rotate : assert property (@(posedge clk) disable iff (!i_rst_n)
        ((i_rx_valid & ~(port_map_t'(1'b1) << last_q)) != '0) |-> !o_rx_ready[last_q]);

    // stalled header stays put until the lookup takes it
    a_hold_stable : assert property (@(posedge clk) disable iff (!i_rst_n)
        m_hdr.valid && !m_hdr.ready |=>
            m_hdr.valid && $stable(m_hdr.hdr) && $stable(m_hdr.src));

endmodule

`default_nettype wire

//--- verilog/mac_lookup.sv
`timescale 1ns/100ps
`default_nettype none
`include "switch_cfg.svh"

module mac_lookup import switch_pkg::*, mac_table_pkg::*; (
    input  wire            clk,
    input  wire            i_rst_n,
    input  wire port_map_t i_link,
    input  wire            i_fwd_ready,
    hdr_if.dst_mp          s_hdr,
    output logic           o_fwd_valid,
    output port_map_t      o_fwd_portmap,
    output fwd_kind_t      o_fwd_kind,
    output port_id_t       o_fwd_src,
    output frame_hdr_t     o_fwd_hdr
);

    lookup_state_t state_q;
    lookup_state_t state_d;

    tbl_entry_t mac_tbl [`SW_TABLE_DEPTH];

    frame_hdr_t cur_hdr;
    port_id_t   cur_src;
    logic       accept;

    tbl_idx_t   wr_idx;
    tbl_idx_t   rd_idx;
    tbl_entry_t rd_entry;
    port_map_t  src_bit;

    port_map_t  dec_map;
    fwd_kind_t  dec_kind;
    port_map_t  fwd_map_q;
    fwd_kind_t  fwd_kind_q;

    assign s_hdr.ready = (state_q == LK_IDLE);
    assign accept      = s_hdr.valid && s_hdr.ready;

    always_comb begin
        state_d = state_q;
        case (state_q)
            LK_IDLE: begin
                if (accept) begin
                    state_d = LK_LEARN;
                end
            end
            LK_LEARN: state_d = LK_READ;
            LK_READ:  state_d = LK_HOLD;
            LK_HOLD: begin
                if (i_fwd_ready) begin
                    state_d = LK_IDLE;
                end
            end
            default:  state_d = LK_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state_q <= LK_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // header under lookup, held until the result is taken
    always_ff @(posedge clk) begin
        if (accept) begin
            cur_hdr <= s_hdr.hdr;
            cur_src <= s_hdr.src;
        end
    end

    assign wr_idx = mac_hash(cur_hdr.smac);
    assign rd_idx = mac_hash(cur_hdr.dmac);

    // learn step, group sources never enter the table
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            for (int i = 0; i < `SW_TABLE_DEPTH; i++) begin
                mac_tbl[i].vld <= 1'b0;
            end
        end else if (state_q == LK_LEARN && !is_multicast(cur_hdr.smac)) begin
            mac_tbl[wr_idx] <= '{vld: 1'b1, mac: cur_hdr.smac, port: cur_src};
        end
    end

    assign rd_entry = mac_tbl[rd_idx];
    assign src_bit  = port_map_t'(1'b1) << cur_src;

    always_comb begin
        if (is_multicast(cur_hdr.dmac) || !rd_entry.vld ||
            rd_entry.mac != cur_hdr.dmac) begin
            // unknown or group destination
            dec_kind = FWD_FLOOD;
            dec_map  = i_link & ~src_bit;
        end else if (rd_entry.port == cur_src) begin
            // destination sits behind the ingress port
            dec_kind = FWD_FILTER;
            dec_map  = '0;
        end else begin
            dec_kind = FWD_UNICAST;
            dec_map  = (port_map_t'(1'b1) << rd_entry.port) & i_link;
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == LK_READ) begin
            fwd_map_q  <= dec_map;
            fwd_kind_q <= dec_kind;
        end
    end

    assign o_fwd_valid   = (state_q == LK_HOLD);
    assign o_fwd_portmap = fwd_map_q;
    assign o_fwd_kind    = fwd_kind_q;
    assign o_fwd_src     = cur_src;
    assign o_fwd_hdr     = cur_hdr;

    // result held while the fabric stalls
    a_fwd_stable : assert property (@(posedge clk) disable iff (!i_rst_n)
        o_fwd_valid && !i_fwd_ready |=>
            o_fwd_valid && $stable(o_fwd_portmap) && $stable(o_fwd_kind) &&
            $stable(o_fwd_src) && $stable(o_fwd_hdr));

    // learn and read cycles stay quiet, result follows on the second edge
    a_fwd_timing : assert property (@(posedge clk) disable iff (!i_rst_n)
        accept |=> !o_fwd_valid [*2] ##1 o_fwd_valid);

endmodule

`default_nettype wire

//--- verilog/mac_table_pkg.sv
`default_nettype none
`include "switch_cfg.svh"

package mac_table_pkg;

    import switch_pkg::*;

    typedef logic [`SW_HASH_W-1:0] tbl_idx_t;

    typedef struct packed {
        logic                 vld;
        logic [`SW_MAC_W-1:0] mac;
        port_id_t             port;
    } tbl_entry_t;

    typedef enum logic [1:0] {
        LK_IDLE  = 2'd0,
        LK_LEARN = 2'd1,
        LK_READ  = 2'd2,
        LK_HOLD  = 2'd3
    } lookup_state_t;

    // fold all nibbles of the mac together
    function automatic tbl_idx_t mac_hash(input logic [`SW_MAC_W-1:0] mac);
        tbl_idx_t idx;
        idx = '0;
        for (int n = 0; n < `SW_MAC_W / `SW_HASH_W; n++) begin
            idx ^= mac[n*`SW_HASH_W +: `SW_HASH_W];
        end
        return idx;
    endfunction

endpackage

`default_nettype wire

//--- verilog/switch_pkg.sv
`default_nettype none
`include "switch_cfg.svh"

package switch_pkg;

    // port index and one-bit-per-port mask
    typedef logic [$clog2(`SW_NUM_PORTS)-1:0] port_id_t;
    typedef logic [`SW_NUM_PORTS-1:0] port_map_t;

    // header descriptor that stands in for a whole frame
    typedef struct packed {
        logic [`SW_MAC_W-1:0] dmac;
        logic [`SW_MAC_W-1:0] smac;
        logic [`SW_LEN_W-1:0] len;
    } frame_hdr_t;

    typedef enum logic [1:0] {
        FWD_UNICAST = 2'd0,
        FWD_FLOOD   = 2'd1,
        FWD_FILTER  = 2'd2
    } fwd_kind_t;

    // i/g bit, lsb of the first octet on the wire
    function automatic logic is_multicast(input logic [`SW_MAC_W-1:0] mac);
        return mac[`SW_MAC_W-8];
    endfunction

endpackage

`default_nettype wire

//--- verilog/switch_top.sv
`timescale 1ns/100ps
`default_nettype none
`include "switch_cfg.svh"

module switch_top import switch_pkg::*; (
    input  wire                                     clk,
    input  wire                                     i_rst_n,
    input  wire port_map_t                          i_link,

    // receive side, one lane per port
    input  wire port_map_t                          i_rx_valid,
    output port_map_t                               o_rx_ready,
    input  wire [`SW_NUM_PORTS-1:0][`SW_MAC_W-1:0]  i_rx_dmac,
    input  wire [`SW_NUM_PORTS-1:0][`SW_MAC_W-1:0]  i_rx_smac,
    input  wire [`SW_NUM_PORTS-1:0][`SW_LEN_W-1:0]  i_rx_len,

    // forwarding decision
    output logic                                    o_fwd_valid,
    input  wire                                     i_fwd_ready,
    output port_map_t                               o_fwd_portmap,
    output fwd_kind_t                               o_fwd_kind,
    output port_id_t                                o_fwd_src,
    output logic [`SW_MAC_W-1:0]                    o_fwd_dmac,
    output logic [`SW_MAC_W-1:0]                    o_fwd_smac,
    output logic [`SW_LEN_W-1:0]                    o_fwd_len
);

    wire frame_hdr_t [`SW_NUM_PORTS-1:0] rx_hdr;
    wire frame_hdr_t                     fwd_hdr;

    for (genvar p = 0; p < `SW_NUM_PORTS; p++) begin : g_rx_pack
        assign rx_hdr[p] = '{dmac: i_rx_dmac[p], smac: i_rx_smac[p], len: i_rx_len[p]};
    end

    hdr_if u_hdr_if ();

    interface_mux u_interface_mux (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_rx_valid (i_rx_valid),
        .i_rx_hdr   (rx_hdr),
        .o_rx_ready (o_rx_ready),
        .m_hdr      (u_hdr_if.src_mp)
    );

    mac_lookup u_mac_lookup (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_link        (i_link),
        .i_fwd_ready   (i_fwd_ready),
        .s_hdr         (u_hdr_if.dst_mp),
        .o_fwd_valid   (o_fwd_valid),
        .o_fwd_portmap (o_fwd_portmap),
        .o_fwd_kind    (o_fwd_kind),
        .o_fwd_src     (o_fwd_src),
        .o_fwd_hdr     (fwd_hdr)
    );

    assign o_fwd_dmac = fwd_hdr.dmac;
    assign o_fwd_smac = fwd_hdr.smac;
    assign o_fwd_len  = fwd_hdr.len;

endmodule

`default_nettype wire
